// ==== pr_wrapper.f ====
common/pr_core_pkg.sv
src/pipe_reg.sv
core/proc_timer.sv
core/pkt_mem.sv
core/desc_fsm.sv
core/bc_msg_unit.sv
core/pr_core.sv
src/pr_wrapper.sv
verification/tb_pr_wrapper.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the wrapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f pr_wrapper.f \
  --top-module tb_pr_wrapper -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_pr_wrapper > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// ==== verification/tb_pr_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pr_wrapper import pr_core_pkg::*; ();

  localparam int slot_count     = 16;
  localparam int n_wr           = 48;
  localparam int n_rd           = 48;
  localparam int n_desc         = 20;
  localparam int n_bcw          = 24;
  localparam int n_bcin         = 8;
  localparam int n_post         = 16;
  localparam int total_ops      = 256 + n_wr + n_rd + n_desc + n_bcw + 2 * n_bcin + n_post + 16;
  localparam int timeout_cycles = 20 * total_ops;
  localparam logic [31:0] seed  = 32'hab99_7bf2;

  logic              clk;
  logic              arst_n;
  logic              core_reset;
  dma_wr_t           dma_wr;
  logic              dma_wr_valid;
  logic              dma_wr_ready;
  dma_rd_t           dma_rd;
  logic              dma_rd_valid;
  logic              dma_rd_ready;
  logic [data_w-1:0] rd_resp;
  logic              rd_resp_valid;
  logic              rd_resp_ready;
  desc_u             in_desc;
  logic              in_desc_valid;
  logic              in_desc_ready;
  desc_u             out_desc;
  logic              out_desc_valid;
  logic              out_desc_ready;
  bc_msg_t           bc_in;
  logic              bc_in_valid;
  bc_msg_t           bc_out;
  logic              bc_out_valid;
  logic              bc_out_ready;
  logic [2:0]        wrapper_status_addr;
  status_t           wrapper_status_data;
  logic [1:0]        core_status_addr;
  status_t           core_status_data;

  // Model state
  logic [63:0] mem_model [256];
  logic [3:0]  port_xor_m;
  logic [31:0] pkt_count;
  logic [31:0] bc_count;
  logic [31:0] status0;
  logic [63:0] exp_rd [$];
  desc_u       exp_desc [$];
  bc_msg_t     exp_bc [$];
  logic [31:0] rng;
  logic [2:0]  ready_bits;
  int          cycle_count = 0;

  pr_wrapper #(.REG_LENGTH(1), .SLOT_COUNT(slot_count)) i_dut (.*);

  always #4 clk = ~clk;

  ////////////////////////////////////////
  // Random numbers and checks
  ////////////////////////////////////////
  function automatic logic [31:0] next_state(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      rng = next_state(rng);
      v   = {v[62:0], rng[0]};
    end
    return v;
  endfunction

  task automatic abort_run;
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_desc(input string name, input desc_u got, input desc_u exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_msg(input string name, input bc_msg_t got, input bc_msg_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_status(input string name, input status_t got, input status_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      abort_run();
    end
  end

  // Random ready on the outputs and in-order compare
  always @(posedge clk) begin
    ready_bits = 3'(rand_bits(3));
    #1;
    rd_resp_ready  = ready_bits[2];
    out_desc_ready = ready_bits[1];
    bc_out_ready   = ready_bits[0];
    if (rd_resp_valid && rd_resp_ready) begin
      if (exp_rd.size() == 0) begin
        $display("Read response at %0t with no read pending", $time);
        abort_run();
      end else check_word("rd_resp", rd_resp, exp_rd.pop_front());
    end
    if (out_desc_valid && out_desc_ready) begin
      if (exp_desc.size() == 0) begin
        $display("Descriptor at %0t that should have been dropped", $time);
        abort_run();
      end else check_desc("out_desc", out_desc, exp_desc.pop_front());
    end
    if (bc_out_valid && bc_out_ready) begin
      if (exp_bc.size() == 0) begin
        $display("Broadcast message at %0t with none expected", $time);
        abort_run();
      end else check_msg("bc_out", bc_out, exp_bc.pop_front());
    end
  end

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////
  task automatic step;
    @(posedge clk);
    #1;
  endtask

  task automatic dma_write(input logic [7:0] a, input logic [63:0] data, input logic [7:0] strb);
    logic    acc;
    bc_msg_t m;
    dma_wr.addr  = a;
    dma_wr.data  = data;
    dma_wr.strb  = strb;
    dma_wr_valid = 1'b1;
    acc = 1'b0;
    while (!acc) begin
      acc = dma_wr_ready;
      step();
    end
    dma_wr_valid = 1'b0;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) mem_model[a][8*i +: 8] = data[8*i +: 8];
    end
    if (a >= bc_base && |strb[3:0]) begin
      m.addr = a;
      m.data = mem_model[a][31:0];
      exp_bc.push_back(m);
      bc_count++;
    end
  endtask

  task automatic dma_read(input logic [7:0] a);
    logic acc;
    dma_rd.addr  = a;
    dma_rd_valid = 1'b1;
    acc = 1'b0;
    while (!acc) begin
      acc = dma_rd_ready;
      step();
    end
    dma_rd_valid = 1'b0;
    exp_rd.push_back(mem_model[a]);
  endtask

  task automatic send_desc(input desc_u d);
    logic  acc;
    desc_u e;
    in_desc       = d;
    in_desc_valid = 1'b1;
    acc = 1'b0;
    while (!acc) begin
      acc = in_desc_ready;
      step();
    end
    in_desc_valid = 1'b0;
    if (d.cfg.kind == kind_cfg && d.cfg.reg_sel == 4'd0) begin
      port_xor_m = d.cfg.value[3:0];
    end else if (d.pkt.kind == kind_pkt && d.pkt.slot < 8'(slot_count)) begin
      e          = d;
      e.pkt.port = d.pkt.port ^ port_xor_m;
      exp_desc.push_back(e);
      pkt_count++;
    end
  endtask

  task automatic send_pkt;
    desc_u d;
    d.pkt.kind = kind_pkt;
    d.pkt.port = 4'(rand_bits(4));
    d.pkt.slot = 8'(rand_bits(5));
    d.pkt.len  = 16'(rand_bits(6));
    d.pkt.rsvd = 32'(rand_bits(32));
    send_desc(d);
  endtask

  task automatic send_cfg(input logic [3:0] sel);
    desc_u d;
    d.cfg.kind    = kind_cfg;
    d.cfg.reg_sel = sel;
    d.cfg.rsvd    = 24'(rand_bits(24));
    d.cfg.value   = 32'(rand_bits(32));
    send_desc(d);
  endtask

  task automatic send_bc_in(input logic [7:0] a, input logic [31:0] d);
    bc_in.addr  = a;
    bc_in.data  = d;
    bc_in_valid = 1'b1;
    step();
    bc_in_valid = 1'b0;
    mem_model[a][31:0] = d;
  endtask

  task automatic wait_idle;
    while (exp_rd.size() != 0 || exp_desc.size() != 0 || exp_bc.size() != 0) step();
    repeat (6) step();
  endtask

  task automatic expect_status(input logic [1:0] sel, input logic [31:0] val, input string name);
    status_t e;
    e.data = val;
    while (core_status_addr != sel) step();
    check_status(name, core_status_data, e);
    step();
    check_addr("core_status_addr", core_status_addr, sel + 2'd1);
  endtask

  task automatic expect_all_status;
    expect_status(2'd0, pkt_count, "core_status_data[pkt count]");
    expect_status(2'd1, bc_count, "core_status_data[bc count]");
    expect_status(2'd2, status0, "core_status_data[wrapper status 0]");
    expect_status(2'd3, {28'd0, port_xor_m}, "core_status_data[port_xor]");
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    logic [7:0]  a;
    logic [63:0] data;
    logic [7:0]  strb;
    logic [7:0]  bc_addrs [n_bcin];
    rng                 = seed;
    clk                 = 1'b0;
    arst_n              = 1'b0;
    core_reset          = 1'b0;
    dma_wr              = '0;
    dma_wr_valid        = 1'b0;
    dma_rd              = '0;
    dma_rd_valid        = 1'b0;
    rd_resp_ready       = 1'b0;
    in_desc             = '0;
    in_desc_valid       = 1'b0;
    out_desc_ready      = 1'b0;
    bc_in               = '0;
    bc_in_valid         = 1'b0;
    bc_out_ready        = 1'b0;
    status0             = 32'(rand_bits(32));
    wrapper_status_addr = 3'd0;
    wrapper_status_data.data = status0;
    port_xor_m          = '0;
    pkt_count           = '0;
    bc_count            = '0;
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
    step();
    step();

    // Fill every word with known contents
    for (int i = 0; i < 256; i++) begin
      dma_write(8'(i), {8{8'(i)}} ^ 64'h0123_4567_89ab_cdef, 8'hff);
    end
    for (int i = 0; i < n_wr; i++) begin
      a    = 8'(rand_bits(8));
      data = rand_bits(64);
      strb = 8'(rand_bits(8));
      dma_write(a, data, strb);
    end
    wait_idle();
    for (int i = 0; i < n_rd; i++) begin
      a = 8'(rand_bits(8));
      dma_read(a);
    end
    wait_idle();

    // Descriptors with the remap changed halfway
    send_cfg(4'd0);
    send_cfg(4'd3);
    for (int i = 0; i < n_desc; i++) begin
      if (i == n_desc / 2) send_cfg(4'd0);
      send_pkt();
    end
    wait_idle();

    // Broadcast region writes with some low strobes off
    for (int i = 0; i < n_bcw; i++) begin
      if (rand_bits(1) == 64'd1) a = bc_base + 8'(rand_bits(5));
      else a = 8'(rand_bits(8));
      data = rand_bits(64);
      strb = 8'(rand_bits(8));
      if (i % 6 == 5) strb[3:0] = 4'h0;
      dma_write(a, data, strb);
    end
    wait_idle();

    for (int i = 0; i < n_bcin; i++) begin
      bc_addrs[i] = 8'(rand_bits(8));
      send_bc_in(bc_addrs[i], 32'(rand_bits(32)));
    end
    wait_idle();
    for (int i = 0; i < n_bcin; i++) begin
      dma_read(bc_addrs[i]);
    end
    wait_idle();
    expect_all_status();

    // Only entry 0 of the status file is shown
    wrapper_status_addr      = 3'd5;
    wrapper_status_data.data = 32'(rand_bits(32));
    repeat (4) step();
    expect_status(2'd2, status0, "core_status_data[wrapper status 0]");
    status0                  = 32'(rand_bits(32));
    wrapper_status_addr      = 3'd0;
    wrapper_status_data.data = status0;
    repeat (4) step();
    expect_status(2'd2, status0, "core_status_data[wrapper status 0]");

    core_reset = 1'b1;
    step();
    step();
    core_reset = 1'b0;
    port_xor_m = '0;
    pkt_count  = '0;
    bc_count   = '0;
    repeat (4) step();
    expect_all_status();
    for (int i = 0; i < n_post; i++) begin
      a = 8'(rand_bits(8));
      dma_read(a);
    end
    for (int i = 0; i < 4; i++) begin
      send_pkt();
    end
    wait_idle();
    expect_all_status();

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/pr_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module pr_wrapper import pr_core_pkg::*; #(
  parameter int REG_LENGTH = 1,
  parameter int SLOT_COUNT = 16
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              core_reset,

  input  dma_wr_t           dma_wr,
  input  logic              dma_wr_valid,
  output logic              dma_wr_ready,
  input  dma_rd_t           dma_rd,
  input  logic              dma_rd_valid,
  output logic              dma_rd_ready,
  output logic [data_w-1:0] rd_resp,
  output logic              rd_resp_valid,
  input  logic              rd_resp_ready,

  input  desc_u             in_desc,
  input  logic              in_desc_valid,
  output logic              in_desc_ready,
  output desc_u             out_desc,
  output logic              out_desc_valid,
  input  logic              out_desc_ready,

  input  bc_msg_t           bc_in,
  input  logic              bc_in_valid,
  output bc_msg_t           bc_out,
  output logic              bc_out_valid,
  input  logic              bc_out_ready,

  input  logic [2:0]        wrapper_status_addr,
  input  status_t           wrapper_status_data,
  output logic [1:0]        core_status_addr,
  output status_t           core_status_data
);

  ////////////////////////////////////////
  // Reset copies and status flops
  ////////////////////////////////////////
  logic       arst_n_r;
  logic       core_reset_r;
  logic [2:0] wrapper_status_addr_r;
  status_t    wrapper_status_data_r;
  logic [1:0] core_status_addr_n;
  status_t    core_status_data_n;

  // Asserts at once, releases on the clock
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      arst_n_r     <= 1'b0;
      core_reset_r <= 1'b0;
    end else begin
      arst_n_r     <= 1'b1;
      core_reset_r <= core_reset;
    end
  end

  always_ff @(posedge clk or negedge arst_n_r) begin
    if (!arst_n_r) begin
      wrapper_status_addr_r <= '0;
      wrapper_status_data_r <= '0;
      core_status_addr      <= '0;
      core_status_data      <= '0;
    end else begin
      wrapper_status_addr_r <= wrapper_status_addr;
      wrapper_status_data_r <= wrapper_status_data;
      core_status_addr      <= core_status_addr_n;
      core_status_data      <= core_status_data_n;
    end
  end

  ////////////////////////////////////////
  // Boundary slices
  ////////////////////////////////////////
  dma_wr_t           dma_wr_r;
  logic              dma_wr_valid_r;
  logic              dma_wr_ready_r;
  dma_rd_t           dma_rd_r;
  logic              dma_rd_valid_r;
  logic              dma_rd_ready_r;
  logic [data_w-1:0] rd_resp_n;
  logic              rd_resp_valid_n;
  logic              rd_resp_ready_n;
  desc_u             in_desc_r;
  logic              in_desc_valid_r;
  logic              in_desc_ready_r;
  desc_u             out_desc_n;
  logic              out_desc_valid_n;
  logic              out_desc_ready_n;
  bc_msg_t           bc_in_r;
  logic              bc_in_valid_r;
  bc_msg_t           bc_out_n;
  logic              bc_out_valid_n;
  logic              bc_out_ready_n;

  pipe_reg #(.DATA_WIDTH($bits(dma_wr_t)), .REG_LENGTH(REG_LENGTH)) dma_wr_reg (
    .clk(clk), .arst_n(arst_n_r), .clear(1'b0),
    .s_data(dma_wr), .s_valid(dma_wr_valid), .s_ready(dma_wr_ready),
    .m_data(dma_wr_r), .m_valid(dma_wr_valid_r), .m_ready(dma_wr_ready_r)
  );

  pipe_reg #(.DATA_WIDTH($bits(dma_rd_t)), .REG_LENGTH(REG_LENGTH)) dma_rd_reg (
    .clk(clk), .arst_n(arst_n_r), .clear(1'b0),
    .s_data(dma_rd), .s_valid(dma_rd_valid), .s_ready(dma_rd_ready),
    .m_data(dma_rd_r), .m_valid(dma_rd_valid_r), .m_ready(dma_rd_ready_r)
  );

  pipe_reg #(.DATA_WIDTH(data_w), .REG_LENGTH(REG_LENGTH)) rd_resp_reg (
    .clk(clk), .arst_n(arst_n_r), .clear(1'b0),
    .s_data(rd_resp_n), .s_valid(rd_resp_valid_n), .s_ready(rd_resp_ready_n),
    .m_data(rd_resp), .m_valid(rd_resp_valid), .m_ready(rd_resp_ready)
  );

  pipe_reg #(.DATA_WIDTH($bits(desc_u)), .REG_LENGTH(REG_LENGTH)) in_desc_reg (
    .clk(clk), .arst_n(arst_n_r), .clear(core_reset_r),
    .s_data(in_desc), .s_valid(in_desc_valid), .s_ready(in_desc_ready),
    .m_data(in_desc_r), .m_valid(in_desc_valid_r), .m_ready(in_desc_ready_r)
  );

  pipe_reg #(.DATA_WIDTH($bits(desc_u)), .REG_LENGTH(REG_LENGTH)) out_desc_reg (
    .clk(clk), .arst_n(arst_n_r), .clear(core_reset_r),
    .s_data(out_desc_n), .s_valid(out_desc_valid_n), .s_ready(out_desc_ready_n),
    .m_data(out_desc), .m_valid(out_desc_valid), .m_ready(out_desc_ready)
  );

  // No back-pressure on incoming broadcasts
  pipe_reg #(.DATA_WIDTH($bits(bc_msg_t)), .REG_LENGTH(REG_LENGTH)) bc_in_reg (
    .clk(clk), .arst_n(arst_n_r), .clear(core_reset_r),
    .s_data(bc_in), .s_valid(bc_in_valid), .s_ready(),
    .m_data(bc_in_r), .m_valid(bc_in_valid_r), .m_ready(1'b1)
  );

  pipe_reg #(.DATA_WIDTH($bits(bc_msg_t)), .REG_LENGTH(REG_LENGTH)) bc_out_reg (
    .clk(clk), .arst_n(arst_n_r), .clear(1'b0),
    .s_data(bc_out_n), .s_valid(bc_out_valid_n), .s_ready(bc_out_ready_n),
    .m_data(bc_out), .m_valid(bc_out_valid), .m_ready(bc_out_ready)
  );

  pr_core #(.SLOT_COUNT(SLOT_COUNT)) core_inst (
    .clk(clk),
    .arst_n(arst_n_r),
    .rst_core(core_reset_r),
    .dma_wr(dma_wr_r),
    .dma_wr_valid(dma_wr_valid_r),
    .dma_wr_ready(dma_wr_ready_r),
    .dma_rd(dma_rd_r),
    .dma_rd_valid(dma_rd_valid_r),
    .dma_rd_ready(dma_rd_ready_r),
    .rd_resp(rd_resp_n),
    .rd_resp_valid(rd_resp_valid_n),
    .rd_resp_ready(rd_resp_ready_n),
    .in_desc(in_desc_r),
    .in_desc_valid(in_desc_valid_r),
    .in_desc_ready(in_desc_ready_r),
    .out_desc(out_desc_n),
    .out_desc_valid(out_desc_valid_n),
    .out_desc_ready(out_desc_ready_n),
    .bc_in(bc_in_r),
    .bc_in_valid(bc_in_valid_r),
    .bc_out(bc_out_n),
    .bc_out_valid(bc_out_valid_n),
    .bc_out_ready(bc_out_ready_n),
    .wrapper_status_addr(wrapper_status_addr_r),
    .wrapper_status_data(wrapper_status_data_r),
    .core_status_addr(core_status_addr_n),
    .core_status_data(core_status_data_n)
  );

endmodule

`default_nettype wire

// ==== core/pr_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module pr_core import pr_core_pkg::*; #(
  parameter int SLOT_COUNT = 16
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              rst_core,
  input  dma_wr_t           dma_wr,
  input  logic              dma_wr_valid,
  output logic              dma_wr_ready,
  input  dma_rd_t           dma_rd,
  input  logic              dma_rd_valid,
  output logic              dma_rd_ready,
  output logic [data_w-1:0] rd_resp,
  output logic              rd_resp_valid,
  input  logic              rd_resp_ready,
  input  desc_u             in_desc,
  input  logic              in_desc_valid,
  output logic              in_desc_ready,
  output desc_u             out_desc,
  output logic              out_desc_valid,
  input  logic              out_desc_ready,
  input  bc_msg_t           bc_in,
  input  logic              bc_in_valid,
  output bc_msg_t           bc_out,
  output logic              bc_out_valid,
  input  logic              bc_out_ready,
  input  logic [2:0]        wrapper_status_addr,
  input  status_t           wrapper_status_data,
  output logic [1:0]        core_status_addr,
  output status_t           core_status_data
);

  logic              wr_fire;
  logic [data_w-1:0] wr_word;
  logic              bc_hold;
  logic              bc_sent;
  logic              timer_load;
  logic [13:0]       timer_cycles;
  logic              timer_done;
  logic [3:0]        port_xor;
  logic              pkt_done;
  logic [31:0]       pkt_cnt;
  logic [31:0]       bc_cnt;
  logic [1:0]        stat_sel;
  status_t           status_rf [8];

  // Incoming broadcast wins the write port
  assign dma_wr_ready = !bc_hold && !bc_in_valid;
  assign wr_fire      = dma_wr_valid && dma_wr_ready;

  pkt_mem mem_inst (
    .clk(clk), .arst_n(arst_n),
    .wr_en(wr_fire), .wr(dma_wr), .wr_word(wr_word),
    .rd_valid(dma_rd_valid), .rd(dma_rd), .rd_ready(dma_rd_ready),
    .resp_data(rd_resp), .resp_valid(rd_resp_valid), .resp_ready(rd_resp_ready),
    .bc_en(bc_in_valid), .bc(bc_in)
  );

  desc_fsm #(.SLOT_COUNT(SLOT_COUNT)) fsm_inst (
    .clk(clk), .arst_n(arst_n), .clear(rst_core),
    .in_desc(in_desc), .in_valid(in_desc_valid), .in_ready(in_desc_ready),
    .out_desc(out_desc), .out_valid(out_desc_valid), .out_ready(out_desc_ready),
    .timer_load(timer_load), .timer_cycles(timer_cycles), .timer_done(timer_done),
    .port_xor(port_xor), .pkt_done(pkt_done)
  );

  proc_timer timer_inst (
    .clk(clk), .arst_n(arst_n), .clear(rst_core),
    .load(timer_load), .cycles(timer_cycles), .done(timer_done)
  );

  bc_msg_unit bc_inst (
    .clk(clk), .arst_n(arst_n),
    .wr_fire(wr_fire), .wr(dma_wr), .wr_word(wr_word), .hold(bc_hold),
    .msg(bc_out), .msg_valid(bc_out_valid), .msg_ready(bc_out_ready), .sent(bc_sent)
  );

  ////////////////////////////////////////
  // Status
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    status_rf[wrapper_status_addr] <= wrapper_status_data;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pkt_cnt  <= '0;
      bc_cnt   <= '0;
      stat_sel <= '0;
    end else begin
      stat_sel <= stat_sel + 2'd1;
      if (rst_core) begin
        pkt_cnt <= '0;
        bc_cnt  <= '0;
      end else begin
        pkt_cnt <= pkt_cnt + 32'(pkt_done);
        bc_cnt  <= bc_cnt + 32'(bc_sent);
      end
    end
  end

  assign core_status_addr = stat_sel;

  always_comb begin
    case (stat_sel)
      2'd0:    core_status_data.data = pkt_cnt;
      2'd1:    core_status_data.data = bc_cnt;
      2'd2:    core_status_data.data = status_rf[0].data;
      default: core_status_data.data = {28'd0, port_xor};
    endcase
  end

endmodule

`default_nettype wire

// ==== core/bc_msg_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module bc_msg_unit import pr_core_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              wr_fire,
  input  dma_wr_t           wr,
  input  logic [data_w-1:0] wr_word,
  output logic              hold,
  output bc_msg_t           msg,
  output logic              msg_valid,
  input  logic              msg_ready,
  output logic              sent
);

  logic hit;

  // Region write touching the low word
  assign hit  = wr_fire && (wr.addr >= bc_base) && (|wr.strb[3:0]);
  assign hold = msg_valid;
  assign sent = msg_valid && msg_ready;

  always_ff @(posedge clk) begin
    if (hit) begin
      msg.addr <= wr.addr;
      msg.data <= wr_word[31:0];
    end
  end

  // Single slot, DMA is stalled while it is full
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      msg_valid <= 1'b0;
    end else if (hit) begin
      msg_valid <= 1'b1;
    end else if (sent) begin
      msg_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== core/desc_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module desc_fsm import pr_core_pkg::*; #(
  parameter int SLOT_COUNT = 16
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        clear,
  input  desc_u       in_desc,
  input  logic        in_valid,
  output logic        in_ready,
  output desc_u       out_desc,
  output logic        out_valid,
  input  logic        out_ready,
  output logic        timer_load,
  output logic [13:0] timer_cycles,
  input  logic        timer_done,
  output logic [3:0]  port_xor,
  output logic        pkt_done
);

  typedef enum logic [1:0] {
    st_idle,
    st_decode,
    st_wait,
    st_emit
  } state_e;

  state_e state;
  desc_u  desc_q;
  logic   is_pkt;
  logic   is_cfg;

  // Packets on out-of-range slots are dropped here
  assign is_pkt = (desc_q.pkt.kind == kind_pkt) && (desc_q.pkt.slot < SLOT_COUNT);
  assign is_cfg = desc_q.cfg.kind == kind_cfg;

  assign in_ready   = state == st_idle;
  assign out_valid  = state == st_emit;
  assign pkt_done   = out_valid && out_ready;
  assign timer_load = (state == st_decode) && is_pkt;

  // One cycle per 8 bytes, rounded up, plus one
  assign timer_cycles = 14'(((17'(desc_q.pkt.len) + 17'd7) >> 3) + 17'd1);

  always_comb begin
    out_desc          = desc_q;
    out_desc.pkt.port = desc_q.pkt.port ^ port_xor;
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      desc_q <= in_desc;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= st_idle;
      port_xor <= '0;
    end else if (clear) begin
      state    <= st_idle;
      port_xor <= '0;
    end else begin
      case (state)
        st_idle: if (in_valid) state <= st_decode;
        st_decode: begin
          if (is_cfg && desc_q.cfg.reg_sel == 4'd0) begin
            port_xor <= desc_q.cfg.value[3:0];
          end
          state <= is_pkt ? st_wait : st_idle;
        end
        st_wait: if (timer_done) state <= st_emit;
        st_emit: if (out_ready) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== core/pkt_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module pkt_mem import pr_core_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,

  input  logic              wr_en,
  input  dma_wr_t           wr,
  output logic [data_w-1:0] wr_word,

  input  logic              rd_valid,
  input  dma_rd_t           rd,
  output logic              rd_ready,
  output logic [data_w-1:0] resp_data,
  output logic              resp_valid,
  input  logic              resp_ready,

  input  logic              bc_en,
  input  bc_msg_t           bc
);

  logic [data_w-1:0] mem [2**addr_w];

  // Word as it stands after the strobed write
  always_comb begin
    for (int i = 0; i < strb_w; i++) begin
      wr_word[8*i +: 8] = wr.strb[i] ? wr.data[8*i +: 8] : mem[wr.addr][8*i +: 8];
    end
  end

  // New read only once the held response can leave
  assign rd_ready = !resp_valid || resp_ready;

  always_ff @(posedge clk) begin
    if (bc_en) begin
      mem[bc.addr][31:0] <= bc.data;
    end else if (wr_en) begin
      mem[wr.addr] <= wr_word;
    end
    // Same-edge write is not seen by this read
    if (rd_valid && rd_ready) begin
      resp_data <= mem[rd.addr];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      resp_valid <= 1'b0;
    end else if (rd_valid && rd_ready) begin
      resp_valid <= 1'b1;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== core/proc_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module proc_timer (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        clear,
  input  logic        load,
  input  logic [13:0] cycles,
  output logic        done
);

  logic [13:0] cnt;
  logic        busy;

  assign done = busy && (cnt == '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt  <= '0;
      busy <= 1'b0;
    end else if (clear) begin
      cnt  <= '0;
      busy <= 1'b0;
    end else if (load) begin
      cnt  <= cycles;
      busy <= 1'b1;
    end else if (done) begin
      busy <= 1'b0;
    end else if (busy) begin
      cnt <= cnt - 14'd1;
    end
  end

endmodule

`default_nettype wire

// ==== src/pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter int DATA_WIDTH = 8,
  parameter int REG_LENGTH = 1
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  clear,
  input  logic [DATA_WIDTH-1:0] s_data,
  input  logic                  s_valid,
  output logic                  s_ready,
  output logic [DATA_WIDTH-1:0] m_data,
  output logic                  m_valid,
  input  logic                  m_ready
);

  // Index i is the input of stage i, REG_LENGTH the chain output
  logic [DATA_WIDTH-1:0] data_c  [REG_LENGTH+1];
  logic                  valid_c [REG_LENGTH+1];
  logic                  ready_c [REG_LENGTH+1];

  assign data_c[0]           = s_data;
  assign valid_c[0]          = s_valid;
  assign s_ready             = ready_c[0];
  assign m_data              = data_c[REG_LENGTH];
  assign m_valid             = valid_c[REG_LENGTH];
  assign ready_c[REG_LENGTH] = m_ready;

  for (genvar i = 0; i < REG_LENGTH; i++) begin : g_stage
    logic [DATA_WIDTH-1:0] main_q;
    logic [DATA_WIDTH-1:0] spare_q;
    logic                  main_v;
    logic                  spare_v;

    // Ready comes from the spare slot only
    assign ready_c[i]   = !spare_v;
    assign data_c[i+1]  = main_q;
    assign valid_c[i+1] = main_v;

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        main_v  <= 1'b0;
        spare_v <= 1'b0;
      end else if (clear) begin
        main_v  <= 1'b0;
        spare_v <= 1'b0;
      end else if (ready_c[i+1] || !main_v) begin
        main_v  <= spare_v || valid_c[i];
        spare_v <= 1'b0;
      end else if (valid_c[i] && !spare_v) begin
        spare_v <= 1'b1;
      end
    end

    always_ff @(posedge clk) begin
      if (ready_c[i+1] || !main_v) begin
        main_q <= spare_v ? spare_q : data_c[i];
      end
      if (!spare_v) begin
        spare_q <= data_c[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== common/pr_core_pkg.sv ====
`default_nettype none

package pr_core_pkg;

  localparam int data_w = 64;
  localparam int strb_w = 8;
  localparam int addr_w = 8;

  // Broadcast region is the top 32 words
  localparam logic [addr_w-1:0] bc_base = 8'd224;

  typedef enum logic [3:0] {
    kind_pkt = 4'h1,
    kind_cfg = 4'h2
  } desc_kind_e;

  typedef struct packed {
    desc_kind_e  kind;
    logic [3:0]  port;
    logic [7:0]  slot;
    logic [15:0] len;
    logic [31:0] rsvd;
  } desc_pkt_t;

  typedef struct packed {
    desc_kind_e  kind;
    logic [3:0]  reg_sel;
    logic [23:0] rsvd;
    logic [31:0] value;
  } desc_cfg_t;

  // Same word, read by its kind field
  typedef union packed {
    desc_pkt_t pkt;
    desc_cfg_t cfg;
  } desc_u;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
  } dma_wr_t;

  typedef struct packed {
    logic [addr_w-1:0] addr;
  } dma_rd_t;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [31:0]       data;
  } bc_msg_t;

  typedef struct packed {
    logic [31:0] data;
  } status_t;

endpackage

`default_nettype wire
